// File: logic/ninjin_axi_pkg.sv
package ninjin_axi_pkg;

  // ==============================
  // response channel
  // ==============================

  typedef logic [1:0] axi_resp_t;

  // bit 1 of a response marks an error
  localparam axi_resp_t resp_okay   = 2'b00;
  localparam axi_resp_t resp_slverr = 2'b10;

  // ==============================
  // address channel codes
  // ==============================

  // incrementing burst
  localparam logic [1:0] burst_incr = 2'b01;

  // one 32-bit word per beat, log2 of the byte count
  localparam logic [2:0] size_word = 3'd2;

endpackage

// File: logic/ninjin_image_pkg.sv
package ninjin_image_pkg;

  // ==============================
  // word and address geometry
  // ==============================

  localparam int dwidth     = 32;
  localparam int addr_width = 16;

  typedef logic [dwidth-1:0]     image_word_t;
  typedef logic [addr_width-1:0] image_addr_t;

  // engine error code
  // bit 0 set on any response error
  // bit 1 read response error
  // bit 2 write response error
  // bit 3 stays zero
  typedef logic [3:0] err_code_t;

endpackage

// File: logic/ninjin_m_axi_image.sv
`timescale 1ns/1ps

module ninjin_m_axi_image
  import ninjin_axi_pkg::*;
  import ninjin_image_pkg::*;
#(
  parameter int burst_len = 16
) (
  input  logic        clk,
  input  logic        xrst,
  // user side
  input  logic        ddr_we,
  input  logic        ddr_re,
  input  image_addr_t ddr_addr,
  input  image_word_t ddr_wdata,
  output logic        busy,
  output err_code_t   err,
  output image_word_t ddr_rdata,
  output logic        ddr_rvalid,
  // bus side
  output logic        awvalid,
  input  logic        awready,
  output image_addr_t awaddr,
  output logic [7:0]  awlen,
  output logic        wvalid,
  input  logic        wready,
  output image_word_t wdata,
  output logic        wlast,
  input  logic        bvalid,
  output logic        bready,
  input  axi_resp_t   bresp,
  output logic        arvalid,
  input  logic        arready,
  output image_addr_t araddr,
  output logic [7:0]  arlen,
  input  logic        rvalid,
  output logic        rready,
  input  image_word_t rdata,
  input  axi_resp_t   rresp,
  input  logic        rlast
);

  localparam int               idx_w    = $clog2(burst_len) + 1;
  localparam logic [idx_w-1:0] last_idx = idx_w'(burst_len - 1);

  enum logic [1:0] {s_idle, s_write, s_read} state;

  logic             r_we;
  logic             r_re;
  logic             we_pulse;
  logic             re_pulse;
  logic             r_start;
  image_addr_t      r_addr;
  image_word_t      r_wbase;
  logic             r_awvalid;
  logic             r_wvalid;
  logic             r_bready;
  logic             r_arvalid;
  logic             r_rready;
  logic [idx_w-1:0] write_idx;
  logic [idx_w-1:0] read_idx;
  err_code_t        r_err;
  logic             wnext;
  logic             rnext;
  logic             write_end;
  logic             read_end;
  logic             err_wresp;
  logic             err_rresp;

  // ==============================
  // core control
  // ==============================

  assign we_pulse = ddr_we && !r_we;
  assign re_pulse = ddr_re && !r_re;

  assign wnext     = r_wvalid && wready;
  assign rnext     = rvalid && r_rready;
  assign write_end = bvalid && r_bready;
  assign read_end  = rnext && (read_idx == last_idx);

  assign busy = (state != s_idle);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_we <= 1'b0;
      r_re <= 1'b0;
    end else begin
      r_we <= ddr_we;
      r_re <= ddr_re;
    end
  end

  // a write edge wins over a read edge
  always_ff @(posedge clk) begin
    if (!xrst) begin
      state   <= s_idle;
      r_start <= 1'b0;
    end else begin
      r_start <= 1'b0;
      case (state)
        s_idle: begin
          if (we_pulse) begin
            state   <= s_write;
            r_start <= 1'b1;
          end else if (re_pulse) begin
            state   <= s_read;
            r_start <= 1'b1;
          end
        end
        s_write: begin
          if (write_end) begin
            state <= s_idle;
          end
        end
        s_read: begin
          if (read_end) begin
            state <= s_idle;
          end
        end
        default: state <= s_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == s_idle && (we_pulse || re_pulse)) begin
      r_addr <= ddr_addr;
    end
    if (state == s_idle && we_pulse) begin
      r_wbase <= ddr_wdata;
    end
  end

  // ==============================
  // write channels
  // ==============================

  assign awvalid = r_awvalid;
  assign awaddr  = r_addr;
  assign awlen   = 8'(burst_len - 1);
  assign wvalid  = r_wvalid;
  assign wlast   = (write_idx == last_idx);
  assign bready  = r_bready;

  // fill pattern, beat k carries base plus k
  assign wdata = r_wbase + image_word_t'(write_idx);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_awvalid <= 1'b0;
      r_wvalid  <= 1'b0;
      write_idx <= '0;
    end else if (r_start && state == s_write) begin
      r_awvalid <= 1'b1;
      r_wvalid  <= 1'b1;
      write_idx <= '0;
    end else begin
      if (r_awvalid && awready) begin
        r_awvalid <= 1'b0;
      end
      if (wnext && wlast) begin
        r_wvalid <= 1'b0;
      end else if (wnext) begin
        write_idx <= write_idx + 1'b1;
      end
    end
  end

  // one-cycle ready once the response shows up
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_bready <= 1'b0;
    end else begin
      r_bready <= bvalid && !r_bready;
    end
  end

  // ==============================
  // read channels
  // ==============================

  assign arvalid = r_arvalid;
  assign araddr  = r_addr;
  assign arlen   = 8'(burst_len - 1);
  assign rready  = r_rready;

  assign ddr_rdata  = rdata;
  assign ddr_rvalid = rnext;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_arvalid <= 1'b0;
      read_idx  <= '0;
    end else if (r_start && state == s_read) begin
      r_arvalid <= 1'b1;
      read_idx  <= '0;
    end else begin
      if (r_arvalid && arready) begin
        r_arvalid <= 1'b0;
      end
      if (rnext && read_idx != last_idx) begin
        read_idx <= read_idx + 1'b1;
      end
    end
  end

  // held while beats arrive, dropped after the last one
  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_rready <= 1'b0;
    end else if (state == s_read && rvalid) begin
      r_rready <= !(rlast && r_rready);
    end
  end

  // ==============================
  // error capture
  // ==============================

  assign err_wresp = write_end && bresp[1];
  assign err_rresp = rnext && rresp[1];

  assign err = r_err;

  always_ff @(posedge clk) begin
    if (!xrst) begin
      r_err <= '0;
    end else if (r_start) begin
      r_err <= '0;
    end else if (err_wresp || err_rresp) begin
      r_err <= {1'b0, err_wresp, err_rresp, 1'b1};
    end
  end

endmodule

// File: logic/ninjin_axi_arbiter.sv
`timescale 1ns/1ps

module ninjin_axi_arbiter
  import ninjin_axi_pkg::*;
  import ninjin_image_pkg::*;
(
  input  logic        clk,
  input  logic        xrst,
  // engine 0
  input  logic        awvalid_0, wvalid_0, wlast_0, bready_0, arvalid_0, rready_0,
  input  image_addr_t awaddr_0, araddr_0,
  input  logic [7:0]  awlen_0, arlen_0,
  input  image_word_t wdata_0,
  output logic        awready_0, wready_0, bvalid_0, arready_0, rvalid_0, rlast_0,
  output axi_resp_t   bresp_0, rresp_0,
  output image_word_t rdata_0,
  // engine 1
  input  logic        awvalid_1, wvalid_1, wlast_1, bready_1, arvalid_1, rready_1,
  input  image_addr_t awaddr_1, araddr_1,
  input  logic [7:0]  awlen_1, arlen_1,
  input  image_word_t wdata_1,
  output logic        awready_1, wready_1, bvalid_1, arready_1, rvalid_1, rlast_1,
  output axi_resp_t   bresp_1, rresp_1,
  output image_word_t rdata_1,
  // memory side
  output logic        s_awvalid, s_wvalid, s_wlast, s_bready, s_arvalid, s_rready,
  output image_addr_t s_awaddr, s_araddr,
  output logic [7:0]  s_awlen, s_arlen,
  output image_word_t s_wdata,
  input  logic        s_awready, s_wready, s_bvalid, s_arready, s_rvalid, s_rlast,
  input  axi_resp_t   s_bresp, s_rresp,
  input  image_word_t s_rdata
);

  // one-hot grant, zero while the bus is free
  logic [1:0] gnt;
  logic       kind;
  logic       last_gnt;
  logic       act;
  logic       req_0;
  logic       req_1;
  logic       pick;
  logic       txn_end;
  logic       wr_0, wr_1, rd_0, rd_1;

  assign act   = |gnt;
  assign req_0 = awvalid_0 || arvalid_0;
  assign req_1 = awvalid_1 || arvalid_1;

  // the engine not granted last wins a tie
  assign pick = (req_0 && req_1) ? !last_gnt : req_1;

  // kind high means read
  assign txn_end = kind ? (s_rvalid && s_rready && s_rlast) : (s_bvalid && s_bready);

  always_ff @(posedge clk) begin
    if (!xrst) begin
      gnt      <= 2'b00;
      kind     <= 1'b0;
      last_gnt <= 1'b1;
    end else if (!act || txn_end) begin
      if (req_0 || req_1) begin
        gnt      <= pick ? 2'b10 : 2'b01;
        kind     <= pick ? !awvalid_1 : !awvalid_0;
        last_gnt <= pick;
      end else begin
        gnt <= 2'b00;
      end
    end
  end

  assign wr_0 = gnt[0] && !kind;
  assign wr_1 = gnt[1] && !kind;
  assign rd_0 = gnt[0] && kind;
  assign rd_1 = gnt[1] && kind;

  // ==============================
  // toward the memory
  // ==============================

  assign s_awvalid = (wr_0 && awvalid_0) || (wr_1 && awvalid_1);
  assign s_wvalid  = (wr_0 && wvalid_0) || (wr_1 && wvalid_1);
  assign s_bready  = (wr_0 && bready_0) || (wr_1 && bready_1);
  assign s_arvalid = (rd_0 && arvalid_0) || (rd_1 && arvalid_1);
  assign s_rready  = (rd_0 && rready_0) || (rd_1 && rready_1);

  assign s_awaddr = gnt[1] ? awaddr_1 : awaddr_0;
  assign s_awlen  = gnt[1] ? awlen_1 : awlen_0;
  assign s_wdata  = gnt[1] ? wdata_1 : wdata_0;
  assign s_wlast  = gnt[1] ? wlast_1 : wlast_0;
  assign s_araddr = gnt[1] ? araddr_1 : araddr_0;
  assign s_arlen  = gnt[1] ? arlen_1 : arlen_0;

  // ==============================
  // back to the engines
  // ==============================

  // readies and valids only reach the granted engine
  assign awready_0 = wr_0 && s_awready;
  assign wready_0  = wr_0 && s_wready;
  assign bvalid_0  = wr_0 && s_bvalid;
  assign arready_0 = rd_0 && s_arready;
  assign rvalid_0  = rd_0 && s_rvalid;

  assign awready_1 = wr_1 && s_awready;
  assign wready_1  = wr_1 && s_wready;
  assign bvalid_1  = wr_1 && s_bvalid;
  assign arready_1 = rd_1 && s_arready;
  assign rvalid_1  = rd_1 && s_rvalid;

  assign bresp_0 = s_bresp;
  assign rresp_0 = s_rresp;
  assign rdata_0 = s_rdata;
  assign rlast_0 = s_rlast;
  assign bresp_1 = s_bresp;
  assign rresp_1 = s_rresp;
  assign rdata_1 = s_rdata;
  assign rlast_1 = s_rlast;

endmodule

// File: logic/ninjin_image_mem.sv
`timescale 1ns/1ps

module ninjin_image_mem
  import ninjin_axi_pkg::*;
  import ninjin_image_pkg::*;
#(
  parameter int burst_len = 16,
  parameter int total_len = 12
) (
  input  logic        clk,
  input  logic        xrst,
  input  logic        awvalid, wvalid, wlast, bready, arvalid, rready,
  input  image_addr_t awaddr, araddr,
  input  logic [7:0]  awlen, arlen,
  input  image_word_t wdata,
  output logic        awready, wready, bvalid, arready, rvalid, rlast,
  output axi_resp_t   bresp, rresp,
  output image_word_t rdata
);

  localparam int                  widx_w    = total_len - int'(size_word);
  localparam int                  words     = 2 ** widx_w;
  localparam logic [addr_width:0] mem_bytes = (addr_width + 1)'(2 ** total_len);

  enum logic [1:0] {m_idle, m_write, m_resp, m_read} state;

  image_word_t         mem [0:words-1];
  logic [widx_w-1:0]   idx;
  logic [7:0]          beat;
  logic [7:0]          len;
  logic                range_err;
  image_addr_t         req_addr;
  logic [7:0]          req_len;
  logic [addr_width:0] req_span;
  logic [addr_width:0] req_last;
  logic                req_bad;
  logic                wnext;
  logic                rnext;

  // ==============================
  // request decode
  // ==============================

  assign awready = (state == m_idle) && awvalid;
  assign arready = (state == m_idle) && arvalid && !awvalid;

  assign req_addr = awvalid ? awaddr : araddr;
  assign req_len  = awvalid ? awlen : arlen;

  // last byte of the burst against the memory size
  assign req_span = ((addr_width + 1)'(req_len) + 1'b1) << size_word;
  assign req_last = {1'b0, req_addr} + req_span - 1'b1;
  assign req_bad  = (req_last >= mem_bytes) || (req_len != 8'(burst_len - 1));

  assign wnext = (state == m_write) && wvalid;
  assign rnext = (state == m_read) && rready;

  // ==============================
  // burst sequencing
  // ==============================

  always_ff @(posedge clk) begin
    if (!xrst) begin
      state     <= m_idle;
      idx       <= '0;
      beat      <= '0;
      len       <= '0;
      range_err <= 1'b0;
    end else begin
      case (state)
        m_idle: begin
          if (awready || arready) begin
            state     <= awready ? m_write : m_read;
            idx       <= widx_w'(req_addr >> size_word);
            beat      <= '0;
            len       <= req_len;
            range_err <= req_bad;
          end
        end
        m_write: begin
          if (wnext) begin
            idx <= idx + 1'b1;
            if (wlast) begin
              state <= m_resp;
            end
          end
        end
        m_resp: begin
          if (bready) begin
            state <= m_idle;
          end
        end
        m_read: begin
          if (rnext) begin
            idx  <= idx + 1'b1;
            beat <= beat + 1'b1;
            if (rlast) begin
              state <= m_idle;
            end
          end
        end
        default: state <= m_idle;
      endcase
    end
  end

  // writes outside the memory are dropped
  always_ff @(posedge clk) begin
    if (wnext && !range_err) begin
      mem[idx] <= wdata;
    end
  end

  // ==============================
  // response channels
  // ==============================

  assign wready = (state == m_write);
  assign bvalid = (state == m_resp);
  assign bresp  = range_err ? resp_slverr : resp_okay;

  assign rvalid = (state == m_read);
  assign rlast  = (beat == len);
  assign rresp  = range_err ? resp_slverr : resp_okay;
  assign rdata  = range_err ? '0 : mem[idx];

endmodule

// File: logic/ninjin_image_top.sv
`timescale 1ns/1ps

module ninjin_image_top
  import ninjin_axi_pkg::*;
  import ninjin_image_pkg::*;
#(
  parameter int burst_len = 16,
  parameter int total_len = 12
) (
  input  logic        clk,
  input  logic        xrst,
  input  logic        ddr_we_0, ddr_re_0, ddr_we_1, ddr_re_1,
  input  image_addr_t ddr_addr_0, ddr_addr_1,
  input  image_word_t ddr_wdata_0, ddr_wdata_1,
  output logic        busy_0, busy_1, ddr_rvalid_0, ddr_rvalid_1,
  output err_code_t   err_0, err_1,
  output image_word_t ddr_rdata_0, ddr_rdata_1
);

  // engine 0 bus
  logic        awvalid_0, awready_0, wvalid_0, wready_0, wlast_0, bvalid_0, bready_0;
  logic        arvalid_0, arready_0, rvalid_0, rready_0, rlast_0;
  image_addr_t awaddr_0, araddr_0;
  logic [7:0]  awlen_0, arlen_0;
  image_word_t wdata_0, rdata_0;
  axi_resp_t   bresp_0, rresp_0;

  // engine 1 bus
  logic        awvalid_1, awready_1, wvalid_1, wready_1, wlast_1, bvalid_1, bready_1;
  logic        arvalid_1, arready_1, rvalid_1, rready_1, rlast_1;
  image_addr_t awaddr_1, araddr_1;
  logic [7:0]  awlen_1, arlen_1;
  image_word_t wdata_1, rdata_1;
  axi_resp_t   bresp_1, rresp_1;

  // memory bus
  logic        s_awvalid, s_awready, s_wvalid, s_wready, s_wlast, s_bvalid, s_bready;
  logic        s_arvalid, s_arready, s_rvalid, s_rready, s_rlast;
  image_addr_t s_awaddr, s_araddr;
  logic [7:0]  s_awlen, s_arlen;
  image_word_t s_wdata, s_rdata;
  axi_resp_t   s_bresp, s_rresp;

  ninjin_m_axi_image #(.burst_len(burst_len)) i_engine_0 (
    .clk, .xrst,
    .ddr_we(ddr_we_0), .ddr_re(ddr_re_0), .ddr_addr(ddr_addr_0), .ddr_wdata(ddr_wdata_0),
    .busy(busy_0), .err(err_0), .ddr_rdata(ddr_rdata_0), .ddr_rvalid(ddr_rvalid_0),
    .awvalid(awvalid_0), .awready(awready_0), .awaddr(awaddr_0), .awlen(awlen_0),
    .wvalid(wvalid_0), .wready(wready_0), .wdata(wdata_0), .wlast(wlast_0),
    .bvalid(bvalid_0), .bready(bready_0), .bresp(bresp_0),
    .arvalid(arvalid_0), .arready(arready_0), .araddr(araddr_0), .arlen(arlen_0),
    .rvalid(rvalid_0), .rready(rready_0), .rdata(rdata_0), .rresp(rresp_0), .rlast(rlast_0)
  );

  ninjin_m_axi_image #(.burst_len(burst_len)) i_engine_1 (
    .clk, .xrst,
    .ddr_we(ddr_we_1), .ddr_re(ddr_re_1), .ddr_addr(ddr_addr_1), .ddr_wdata(ddr_wdata_1),
    .busy(busy_1), .err(err_1), .ddr_rdata(ddr_rdata_1), .ddr_rvalid(ddr_rvalid_1),
    .awvalid(awvalid_1), .awready(awready_1), .awaddr(awaddr_1), .awlen(awlen_1),
    .wvalid(wvalid_1), .wready(wready_1), .wdata(wdata_1), .wlast(wlast_1),
    .bvalid(bvalid_1), .bready(bready_1), .bresp(bresp_1),
    .arvalid(arvalid_1), .arready(arready_1), .araddr(araddr_1), .arlen(arlen_1),
    .rvalid(rvalid_1), .rready(rready_1), .rdata(rdata_1), .rresp(rresp_1), .rlast(rlast_1)
  );

  // port names match the wires above
  ninjin_axi_arbiter i_arbiter (.*);

  ninjin_image_mem #(.burst_len(burst_len), .total_len(total_len)) i_mem (
    .clk, .xrst,
    .awvalid(s_awvalid), .awready(s_awready), .awaddr(s_awaddr), .awlen(s_awlen),
    .wvalid(s_wvalid), .wready(s_wready), .wdata(s_wdata), .wlast(s_wlast),
    .bvalid(s_bvalid), .bready(s_bready), .bresp(s_bresp),
    .arvalid(s_arvalid), .arready(s_arready), .araddr(s_araddr), .arlen(s_arlen),
    .rvalid(s_rvalid), .rready(s_rready), .rdata(s_rdata), .rresp(s_rresp), .rlast(s_rlast)
  );

endmodule

// File: testbench/ninjin_image_sva.sv
`timescale 1ns/1ps

module ninjin_image_sva (
  input logic clk,
  input logic xrst,
  input logic s_awvalid, s_awready, s_wvalid, s_wready, s_arvalid, s_arready,
  input logic s_bvalid, s_bready, s_rvalid, s_rready,
  input logic awready_0, wready_0, arready_0, bvalid_0, rvalid_0,
  input logic awready_1, wready_1, arready_1, bvalid_1, rvalid_1
);

  // ==============================
  // valid held until ready
  // ==============================

  a_aw_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_awvalid && !s_awready |=> s_awvalid)
    else $error("awvalid dropped before awready");

  a_w_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_wvalid && !s_wready |=> s_wvalid)
    else $error("wvalid dropped before wready");

  a_ar_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_arvalid && !s_arready |=> s_arvalid)
    else $error("arvalid dropped before arready");

  a_b_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_bvalid && !s_bready |=> s_bvalid)
    else $error("bvalid dropped before bready");

  a_r_hold: assert property (@(posedge clk) disable iff (!xrst)
    s_rvalid && !s_rready |=> s_rvalid)
    else $error("rvalid dropped before rready");

  // ==============================
  // routing to one engine only
  // ==============================

  a_resp_one: assert property (@(posedge clk) disable iff (!xrst)
    !(bvalid_0 && bvalid_1) && !(rvalid_0 && rvalid_1))
    else $error("response channel routed to both engines");

  a_ready_one: assert property (@(posedge clk) disable iff (!xrst)
    !(awready_0 && awready_1) && !(wready_0 && wready_1) && !(arready_0 && arready_1))
    else $error("ready raised toward both engines");

endmodule

bind ninjin_axi_arbiter ninjin_image_sva i_sva (.*);

// File: testbench/ninjin_image_tb.sv
`timescale 1ns/1ps

module ninjin_image_tb
  import ninjin_image_pkg::*;
();

  localparam int burst_len = 16;
  localparam int total_len = 12;
  localparam int mem_words = (2 ** total_len) / 4;
  localparam int max_rows  = 24;

  localparam logic [1:0] op_write = 2'd0;
  localparam logic [1:0] op_read  = 2'd1;
  localparam logic [1:0] op_both  = 2'd2;

  logic        clk;
  logic        xrst;
  logic        ddr_we_0, ddr_re_0, ddr_we_1, ddr_re_1;
  image_addr_t ddr_addr_0, ddr_addr_1;
  image_word_t ddr_wdata_0, ddr_wdata_1;
  logic        busy_0, busy_1, ddr_rvalid_0, ddr_rvalid_1;
  err_code_t   err_0, err_1;
  image_word_t ddr_rdata_0, ddr_rdata_1;

  // ==============================
  // stimulus table and model
  // ==============================

  string       row_name [max_rows];
  logic [1:0]  row_mask [max_rows];
  logic [1:0]  row_op   [max_rows];
  image_addr_t row_addr [max_rows][2];
  image_word_t row_seed [max_rows][2];
  err_code_t   row_err  [max_rows][2];
  int          row_count;

  image_word_t model [mem_words];
  image_word_t beats_0 [$];
  image_word_t beats_1 [$];
  logic [31:0] rng_state;
  int          error_count;
  int          check_count;
  int          cycle_count;
  int          cycle_limit;

  ninjin_image_top #(.burst_len(burst_len), .total_len(total_len)) i_ninjin_image_top (.*);

  always #5 clk = ~clk;

  // read beats, sampled mid-cycle
  always @(negedge clk) begin
    if (ddr_rvalid_0) begin
      beats_0.push_back(ddr_rdata_0);
    end
    if (ddr_rvalid_1) begin
      beats_1.push_back(ddr_rdata_1);
    end
  end

  always @(posedge clk) begin
    cycle_count = cycle_count + 1;
    if (cycle_count >= cycle_limit) begin
      $display("timeout: run did not finish within %0d cycles", cycle_limit);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  function automatic logic [31:0] next_random();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  // last byte of the burst at or beyond the memory end
  function automatic logic past_end(input image_addr_t addr);
    return (int'(addr) + burst_len * 4) > (2 ** total_len);
  endfunction

  task automatic next_cycle();
    @(posedge clk);
    #1;
  endtask

  task automatic check_word(input string name, input image_word_t exp, input image_word_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("** Error: %s: expected %h, actual %h", name, exp, act);
    end
  endtask

  task automatic check_err(input string name, input err_code_t exp, input err_code_t act);
    check_count++;
    if (act !== exp) begin
      error_count++;
      $display("** Error: %s: expected %b, actual %b", name, exp, act);
    end
  endtask

  task automatic check_read(input string name, input image_addr_t addr,
                            input image_word_t got [$]);
    image_word_t exp;
    int          base;
    int          k;
    base = int'(addr) / 4;
    if (got.size() != burst_len) begin
      error_count++;
      $display("%s: %0d read beats received, %0d expected", name, got.size(), burst_len);
    end else begin
      for (k = 0; k < burst_len; k++) begin
        exp = '0;
        if (!past_end(addr)) begin
          exp = model[base + k];
        end
        check_word($sformatf("%s beat %0d", name, k), exp, got[k]);
      end
    end
  endtask

  // out-of-range bursts leave memory untouched
  task automatic apply_write(input image_addr_t addr, input image_word_t seed);
    int k;
    if (!past_end(addr)) begin
      for (k = 0; k < burst_len; k++) begin
        model[int'(addr) / 4 + k] = seed + image_word_t'(k);
      end
    end
  endtask

  task automatic add_row(input string name, input logic [1:0] mask, input logic [1:0] op,
                         input image_addr_t a0, input image_addr_t a1,
                         input image_word_t s0, input image_word_t s1,
                         input err_code_t e0, input err_code_t e1);
    row_name[row_count]    = name;
    row_mask[row_count]    = mask;
    row_op[row_count]      = op;
    row_addr[row_count][0] = a0;
    row_addr[row_count][1] = a1;
    row_seed[row_count][0] = s0;
    row_seed[row_count][1] = s1;
    row_err[row_count][0]  = e0;
    row_err[row_count][1]  = e1;
    row_count++;
  endtask

  task automatic build_table();
    image_addr_t a;
    image_word_t s;
    logic [1:0]  wmask;
    int          i;
    row_count = 0;
    add_row("wr_p0", 2'b01, op_write, 16'h0100, '0, next_random(), '0, 4'b0000, 4'b0000);
    add_row("rd_p1_same", 2'b10, op_read, '0, 16'h0100, '0, '0, 4'b0000, 4'b0000);
    add_row("wr_both", 2'b11, op_write, 16'h0200, 16'h0300, next_random(), next_random(),
            4'b0000, 4'b0000);
    add_row("rd_both", 2'b11, op_read, 16'h0300, 16'h0200, '0, '0, 4'b0000, 4'b0000);
    add_row("wr_edge", 2'b01, op_write, 16'h0fc0, '0, next_random(), '0, 4'b0000, 4'b0000);
    add_row("wr_past_end", 2'b10, op_write, '0, 16'h0fe0, '0, next_random(), 4'b0000, 4'b0101);
    add_row("rd_edge", 2'b01, op_read, 16'h0fc0, '0, '0, '0, 4'b0000, 4'b0000);
    add_row("rd_past_end", 2'b10, op_read, '0, 16'h0ff0, '0, '0, 4'b0000, 4'b0011);
    add_row("rd_after_err", 2'b10, op_read, '0, 16'h0100, '0, '0, 4'b0000, 4'b0000);
    add_row("wr_rd_mix", 2'b11, op_both, 16'h0400, 16'h0200, next_random(), '0,
            4'b0000, 4'b0000);
    // random pairs, read back on the other port
    for (i = 0; i < 4; i++) begin
      a     = image_addr_t'(((next_random() >> 8) % (mem_words - burst_len + 1)) * 4);
      s     = next_random();
      wmask = (i % 2 == 0) ? 2'b01 : 2'b10;
      add_row($sformatf("rand_wr_%0d", i), wmask, op_write, a, a, s, s, 4'b0000, 4'b0000);
      add_row($sformatf("rand_rd_%0d", i), ~wmask, op_read, a, a, '0, '0, 4'b0000, 4'b0000);
    end
  endtask

  task automatic run_row(input int r);
    logic [1:0] we;
    logic [1:0] re;
    int         errors_before;
    errors_before = error_count;
    we = (row_op[r] == op_read) ? 2'b00 : row_mask[r];
    re = (row_op[r] == op_write) ? 2'b00 : row_mask[r];
    // mixed row, port 0 writes while port 1 reads
    if (row_op[r] == op_both) begin
      we = row_mask[r] & 2'b01;
      re = row_mask[r] & 2'b10;
    end
    beats_0.delete();
    beats_1.delete();
    ddr_addr_0  = row_addr[r][0];
    ddr_addr_1  = row_addr[r][1];
    ddr_wdata_0 = row_seed[r][0];
    ddr_wdata_1 = row_seed[r][1];
    ddr_we_0    = we[0];
    ddr_re_0    = re[0];
    ddr_we_1    = we[1];
    ddr_re_1    = re[1];
    next_cycle();
    ddr_we_0 = 1'b0;
    ddr_re_0 = 1'b0;
    ddr_we_1 = 1'b0;
    ddr_re_1 = 1'b0;
    // engines went busy on the edge just passed
    @(negedge clk);
    while ((row_mask[r][0] && busy_0) || (row_mask[r][1] && busy_1)) begin
      @(negedge clk);
    end
    if (row_mask[r][0]) begin
      check_err($sformatf("%s port 0 err", row_name[r]), row_err[r][0], err_0);
    end
    if (row_mask[r][1]) begin
      check_err($sformatf("%s port 1 err", row_name[r]), row_err[r][1], err_1);
    end
    if (re[0]) begin
      check_read($sformatf("%s port 0", row_name[r]), row_addr[r][0], beats_0);
    end
    if (re[1]) begin
      check_read($sformatf("%s port 1", row_name[r]), row_addr[r][1], beats_1);
    end
    if (we[0]) begin
      apply_write(row_addr[r][0], row_seed[r][0]);
    end
    if (we[1]) begin
      apply_write(row_addr[r][1], row_seed[r][1]);
    end
    if (error_count == errors_before) begin
      $display("%s: ok", row_name[r]);
    end else begin
      $display("%s: %0d errors", row_name[r], error_count - errors_before);
    end
    next_cycle();
  endtask

  // ==============================
  // main sequence
  // ==============================

  initial begin
    int r;
    clk         = 1'b0;
    xrst        = 1'b0;
    ddr_we_0    = 1'b0;
    ddr_re_0    = 1'b0;
    ddr_we_1    = 1'b0;
    ddr_re_1    = 1'b0;
    ddr_addr_0  = '0;
    ddr_addr_1  = '0;
    ddr_wdata_0 = '0;
    ddr_wdata_1 = '0;
    rng_state   = 32'h40f5_46d1;
    error_count = 0;
    check_count = 0;
    cycle_count = 0;
    build_table();
    cycle_limit = 16 + row_count * 4 * (burst_len + 20);
    repeat (16) @(posedge clk);
    #1;
    xrst = 1'b1;
    next_cycle();
    for (r = 0; r < row_count; r++) begin
      run_row(r);
    end
    $display("rows %0d, checks %0d, errors %0d", row_count, check_count, error_count);
    if (error_count == 0) begin
      $display("ALL CHECKS PASSED");
    end else begin
      $display("CHECKS FAILED");
    end
    $finish;
  end

endmodule

// File: compile.f
logic/ninjin_axi_pkg.sv
logic/ninjin_image_pkg.sv
logic/ninjin_m_axi_image.sv
logic/ninjin_axi_arbiter.sv
logic/ninjin_image_mem.sv
logic/ninjin_image_top.sv
testbench/ninjin_image_sva.sv
testbench/ninjin_image_tb.sv

// File: run.sh
#!/bin/sh
# build and run the image memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal \
  --top-module ninjin_image_tb -Mdir obj_dir -f compile.f
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

out=$(./obj_dir/Vninjin_image_tb)
status=$?
printf '%s\n' "$out"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if printf '%s\n' "$out" | grep -q '^ALL CHECKS PASSED$'; then
  exit 0
fi
exit 1
